// File: hdl/mips_pkg.sv
// word and register index types, opcode, funct and control enums, reset and halt addresses
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;    // data or address word
  typedef logic [4:0]  reg_idx_t; // register number

  // primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_e;

  // function field of special instructions, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'h00,
    fn_jr   = 6'h08,
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25,
    fn_xor  = 6'h26,
    fn_slt  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,    // signed compare
    alu_sll,    // shift by shamt
    alu_pass_b  // second operand straight through, used by lui
  } alu_op_e;

  // how the 16 bit immediate is widened
  typedef enum logic [1:0] {
    imm_sign,
    imm_zero,
    imm_upper
  } imm_kind_e;

  typedef enum logic {
    wb_alu,
    wb_mem
  } wb_sel_e;

  localparam word_t reset_vector = 32'hbfc0_0000; // first fetch after reset
  localparam word_t halt_address = 32'h0000_0000; // jr here stops the core

endpackage

`default_nettype wire

// File: hdl/pc_unit.sv
// program counter and active flag, next address selection, fetch address
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            clk_enable,
  input  wire mips_pkg::word_t instr,
  input  wire logic            branch_eq,
  input  wire logic            branch_ne,
  input  wire logic            jump,
  input  wire logic            jump_reg,
  input  wire logic            zero,
  input  wire mips_pkg::word_t rs_value,
  output mips_pkg::word_t      pc,
  output mips_pkg::word_t      pc_plus4,
  output logic                 active
);

  mips_pkg::word_t pc_q;
  mips_pkg::word_t pc_next;
  mips_pkg::word_t branch_offset;
  mips_pkg::word_t branch_target;
  mips_pkg::word_t jump_target;
  logic            active_q;
  logic            take_branch;
  logic            retire;
  logic            halting;

  assign pc_plus4 = pc_q + 32'd4;

  // word offset, sign extended and shifted by two
  assign branch_offset = {{14{instr[15]}}, instr[15:0], 2'b00};
  assign branch_target = pc_plus4 + branch_offset;
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // stays in current 256MB region

  assign take_branch = (branch_eq & zero) | (branch_ne & ~zero);
  assign retire      = clk_enable & active_q;
  assign halting     = jump_reg && (rs_value == mips_pkg::halt_address);

  always_comb begin
    if (jump_reg) begin
      pc_next = rs_value;
    end else if (jump) begin
      pc_next = jump_target;
    end else if (take_branch) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q     <= mips_pkg::reset_vector;
      active_q <= 1'b1;
    end else if (retire) begin
      pc_q <= pc_next;
      if (halting) active_q <= 1'b0; // stays low until next reset
    end
  end

  assign pc     = pc_q;
  assign active = active_q;

endmodule

`default_nettype wire

// File: hdl/control_decoder.sv
// opcode and funct decode into alu, operand, writeback, memory and flow controls
`timescale 1ns/10ps
`default_nettype none

module control_decoder (
  input  wire mips_pkg::word_t instr,
  output mips_pkg::alu_op_e    alu_op,
  output mips_pkg::imm_kind_e  imm_kind,
  output logic                 alu_src_imm,
  output logic                 reg_write,
  output logic                 dest_rt,
  output logic                 mem_read,
  output logic                 mem_write,
  output mips_pkg::wb_sel_e    wb_sel,
  output logic                 branch_eq,
  output logic                 branch_ne,
  output logic                 jump,
  output logic                 jump_reg
);

  mips_pkg::opcode_e opcode;
  mips_pkg::funct_e  funct;

  assign opcode = mips_pkg::opcode_e'(instr[31:26]);
  assign funct  = mips_pkg::funct_e'(instr[5:0]);

  always_comb begin
    // no-op unless matched below
    alu_op      = mips_pkg::alu_add;
    imm_kind    = mips_pkg::imm_sign;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    dest_rt     = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    wb_sel      = mips_pkg::wb_alu;
    branch_eq   = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    jump_reg    = 1'b0;

    case (opcode)
      mips_pkg::op_special: begin
        reg_write = 1'b1; // r-type writes rd
        case (funct)
          mips_pkg::fn_sll:  alu_op = mips_pkg::alu_sll;
          mips_pkg::fn_addu: alu_op = mips_pkg::alu_add;
          mips_pkg::fn_subu: alu_op = mips_pkg::alu_sub;
          mips_pkg::fn_and:  alu_op = mips_pkg::alu_and;
          mips_pkg::fn_or:   alu_op = mips_pkg::alu_or;
          mips_pkg::fn_xor:  alu_op = mips_pkg::alu_xor;
          mips_pkg::fn_slt:  alu_op = mips_pkg::alu_slt;
          mips_pkg::fn_jr: begin
            reg_write = 1'b0;
            jump_reg  = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      mips_pkg::op_j:   jump = 1'b1;
      mips_pkg::op_beq: branch_eq = 1'b1; // compare comes from the alu zero flag
      mips_pkg::op_bne: branch_ne = 1'b1;
      mips_pkg::op_addiu, mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_lui: begin
        reg_write   = 1'b1;
        dest_rt     = 1'b1;
        alu_src_imm = 1'b1;
        case (opcode)
          mips_pkg::op_andi: begin
            alu_op   = mips_pkg::alu_and;
            imm_kind = mips_pkg::imm_zero;
          end
          mips_pkg::op_ori: begin
            alu_op   = mips_pkg::alu_or;
            imm_kind = mips_pkg::imm_zero;
          end
          mips_pkg::op_lui: begin
            alu_op   = mips_pkg::alu_pass_b;
            imm_kind = mips_pkg::imm_upper;
          end
          default: alu_op = mips_pkg::alu_add; // addiu
        endcase
      end
      mips_pkg::op_lw: begin
        reg_write   = 1'b1;
        dest_rt     = 1'b1;
        alu_src_imm = 1'b1; // base plus offset
        mem_read    = 1'b1;
        wb_sel      = mips_pkg::wb_mem;
      end
      mips_pkg::op_sw: begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/regfile.sv
// 32 entry register file, two combinational reads, one clocked write, v0 export
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               we3,
  input  wire mips_pkg::reg_idx_t ra1,
  input  wire mips_pkg::reg_idx_t ra2,
  input  wire mips_pkg::reg_idx_t wa3,
  input  wire mips_pkg::word_t    wd3,
  output mips_pkg::word_t         rd1,
  output mips_pkg::word_t         rd2,
  output mips_pkg::word_t         reg_v0
);

  mips_pkg::word_t rf [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (we3) begin
      rf[wa3] <= wd3; // writes to r0 land but are never seen
    end
  end

  // r0 always reads as zero
  assign rd1 = (ra1 != 5'd0) ? rf[ra1] : '0;
  assign rd2 = (ra2 != 5'd0) ? rf[ra2] : '0;

  assign reg_v0 = rf[2];

endmodule

`default_nettype wire

// File: hdl/alu.sv
// immediate widening, operand select, arithmetic/logic/shift operations and equality flag
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire mips_pkg::word_t     rd1,
  input  wire mips_pkg::word_t     rd2,
  input  wire mips_pkg::word_t     instr,
  input  wire mips_pkg::alu_op_e   alu_op,
  input  wire mips_pkg::imm_kind_e imm_kind,
  input  wire logic                alu_src_imm,
  output mips_pkg::word_t          result,
  output logic                     zero
);

  mips_pkg::word_t imm_ext;
  mips_pkg::word_t operand_b;
  logic [4:0]      shamt;

  always_comb begin
    case (imm_kind)
      mips_pkg::imm_zero:  imm_ext = {16'b0, instr[15:0]};
      mips_pkg::imm_upper: imm_ext = {instr[15:0], 16'b0}; // lui
      default:             imm_ext = {{16{instr[15]}}, instr[15:0]};
    endcase
  end

  assign operand_b = alu_src_imm ? imm_ext : rd2;
  assign shamt     = instr[10:6];

  always_comb begin
    case (alu_op)
      mips_pkg::alu_add: result = rd1 + operand_b;
      mips_pkg::alu_sub: result = rd1 - operand_b;
      mips_pkg::alu_and: result = rd1 & operand_b;
      mips_pkg::alu_or:  result = rd1 | operand_b;
      mips_pkg::alu_xor: result = rd1 ^ operand_b;
      mips_pkg::alu_slt: result = {31'b0, $signed(rd1) < $signed(operand_b)};
      mips_pkg::alu_sll: result = operand_b << shamt; // shifts rt
      default:           result = operand_b;
    endcase
  end

  // compares the two register reads for beq and bne
  assign zero = (rd1 == rd2);

endmodule

`default_nettype wire

// File: hdl/writeback_unit.sv
// data memory port drive, retire qualification, destination and writeback value select
`timescale 1ns/10ps
`default_nettype none

module writeback_unit (
  input  wire logic              clk_enable,
  input  wire logic              active,
  input  wire logic              reset,
  input  wire mips_pkg::word_t   instr,
  input  wire mips_pkg::word_t   result,
  input  wire mips_pkg::word_t   rd2,
  input  wire mips_pkg::word_t   data_rdata,
  input  wire logic              reg_write,
  input  wire logic              dest_rt,
  input  wire logic              mem_read,
  input  wire logic              mem_write,
  input  wire mips_pkg::wb_sel_e wb_sel,
  output mips_pkg::word_t        data_addr,
  output mips_pkg::word_t        data_wdata,
  output logic                   data_read,
  output logic                   data_write,
  output logic                   we3,
  output mips_pkg::reg_idx_t     wa3,
  output mips_pkg::word_t        wd3
);

  logic commit_ok; // this cycle retires an instruction

  assign commit_ok = active & clk_enable & ~reset;

  assign data_addr  = result;                // base plus offset from the alu
  assign data_wdata = rd2;                   // rt value for sw
  assign data_read  = mem_read & commit_ok;
  assign data_write = mem_write & commit_ok;

  assign we3 = reg_write & commit_ok;
  assign wa3 = dest_rt ? instr[20:16] : instr[15:11]; // rt for i-type, rd for r-type
  assign wd3 = (wb_sel == mips_pkg::wb_mem) ? data_rdata : result;

endmodule

`default_nettype wire

// File: hdl/mips_cpu.sv
// single cycle core top level wiring pc, decoder, register file, alu and writeback
`timescale 1ns/10ps
`default_nettype none

module mips_cpu (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            clk_enable,
  output mips_pkg::word_t      instr_addr,
  input  wire mips_pkg::word_t instr_rdata,
  output mips_pkg::word_t      data_addr,
  output mips_pkg::word_t      data_wdata,
  input  wire mips_pkg::word_t data_rdata,
  output logic                 data_read,
  output logic                 data_write,
  output logic                 active,
  output mips_pkg::word_t      reg_v0
);

  mips_pkg::alu_op_e   alu_op;
  mips_pkg::imm_kind_e imm_kind;
  mips_pkg::wb_sel_e   wb_sel;
  logic                alu_src_imm;
  logic                reg_write;
  logic                dest_rt;
  logic                mem_read;
  logic                mem_write;
  logic                branch_eq;
  logic                branch_ne;
  logic                jump;
  logic                jump_reg;
  mips_pkg::word_t     rd1;
  mips_pkg::word_t     rd2;
  mips_pkg::word_t     result;
  logic                zero;
  logic                we3;
  mips_pkg::reg_idx_t  wa3;
  mips_pkg::word_t     wd3;

  pc_unit i_pc_unit (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .instr      (instr_rdata),
    .branch_eq  (branch_eq),
    .branch_ne  (branch_ne),
    .jump       (jump),
    .jump_reg   (jump_reg),
    .zero       (zero),
    .rs_value   (rd1),
    .pc         (instr_addr),
    .pc_plus4   (),           // no link writeback in this subset
    .active     (active)
  );

  control_decoder i_control_decoder (
    .instr       (instr_rdata),
    .alu_op      (alu_op),
    .imm_kind    (imm_kind),
    .alu_src_imm (alu_src_imm),
    .reg_write   (reg_write),
    .dest_rt     (dest_rt),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .wb_sel      (wb_sel),
    .branch_eq   (branch_eq),
    .branch_ne   (branch_ne),
    .jump        (jump),
    .jump_reg    (jump_reg)
  );

  regfile i_regfile (
    .clk    (clk),
    .reset  (reset),
    .we3    (we3),
    .ra1    (instr_rdata[25:21]), // rs
    .ra2    (instr_rdata[20:16]), // rt
    .wa3    (wa3),
    .wd3    (wd3),
    .rd1    (rd1),
    .rd2    (rd2),
    .reg_v0 (reg_v0)
  );

  alu i_alu (
    .rd1         (rd1),
    .rd2         (rd2),
    .instr       (instr_rdata),
    .alu_op      (alu_op),
    .imm_kind    (imm_kind),
    .alu_src_imm (alu_src_imm),
    .result      (result),
    .zero        (zero)
  );

  writeback_unit i_writeback_unit (
    .clk_enable (clk_enable),
    .active     (active),
    .reset      (reset),
    .instr      (instr_rdata),
    .result     (result),
    .rd2        (rd2),
    .data_rdata (data_rdata),
    .reg_write  (reg_write),
    .dest_rt    (dest_rt),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .wb_sel     (wb_sel),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_read  (data_read),
    .data_write (data_write),
    .we3        (we3),
    .wa3        (wa3),
    .wd3        (wd3)
  );

endmodule

`default_nettype wire

// File: bench/mips_cpu_tb.sv
// testbench with clock and reset, memory models, lfsr program, reference model and compare tasks
`timescale 1ns/10ps
`default_nettype none

module mips_cpu_tb;

  logic            clk;
  logic            reset;
  logic            clk_enable;
  mips_pkg::word_t instr_addr;
  mips_pkg::word_t instr_rdata;
  mips_pkg::word_t data_addr;
  mips_pkg::word_t data_wdata;
  mips_pkg::word_t data_rdata;
  logic            data_read;
  logic            data_write;
  logic            active;
  mips_pkg::word_t reg_v0;

  mips_pkg::word_t prog [$];      // program words from reset_vector upwards
  mips_pkg::word_t data_mem [64];
  mips_pkg::word_t m_reg [32];    // reference model state
  mips_pkg::word_t m_mem [64];
  mips_pkg::word_t m_pc;
  logic            m_active;
  logic            exp_store;
  logic            exp_load;
  mips_pkg::word_t exp_addr;
  mips_pkg::word_t exp_data;
  logic [15:0]     lfsr_state = 16'd46208;
  int              value_errors = 0;
  int              other_errors = 0;
  int              retired = 0;
  logic            was_frozen = 1'b0;
  mips_pkg::word_t frozen_addr;
  mips_pkg::word_t frozen_v0;

  mips_cpu i_dut (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata),
    .data_rdata  (data_rdata),
    .data_read   (data_read),
    .data_write  (data_write),
    .active      (active),
    .reg_v0      (reg_v0)
  );

  always #10 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic mips_pkg::word_t enc_r(input mips_pkg::funct_e fn, input int rs, rt, rd, sh);
    return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
  endfunction

  function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_e op, input int rs, rt,
                                            input logic [15:0] imm);
    return {op, rs[4:0], rt[4:0], imm};
  endfunction

  function automatic mips_pkg::word_t fetch(input mips_pkg::word_t addr);
    mips_pkg::word_t idx;
    idx = (addr - mips_pkg::reset_vector) >> 2;
    if (idx < prog.size()) return prog[idx];
    return 32'h0; // nop outside the program
  endfunction

  assign instr_rdata = fetch(instr_addr);
  assign data_rdata  = data_mem[data_addr[7:2]];

  always @(posedge clk) begin
    if (data_write) data_mem[data_addr[7:2]] <= data_wdata;
  end

  // executes one instruction on the model, sets the expected data port activity
  function automatic void execute_model(input mips_pkg::word_t ins);
    mips_pkg::word_t a;
    mips_pkg::word_t b;
    mips_pkg::word_t pc4;
    mips_pkg::word_t simm;
    mips_pkg::word_t res;
    logic [4:0]      dst;
    logic            wr;
    a = m_reg[ins[25:21]];
    b = m_reg[ins[20:16]];
    pc4 = m_pc + 32'd4;
    simm = {{16{ins[15]}}, ins[15:0]};
    dst = ins[20:16]; // rt unless r-type
    wr = 1'b1;
    res = '0;
    exp_store = 1'b0;
    exp_load = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    m_pc = pc4;
    case (ins[31:26])
      mips_pkg::op_special: begin
        dst = ins[15:11];
        case (ins[5:0])
          mips_pkg::fn_sll:  res = b << ins[10:6];
          mips_pkg::fn_addu: res = a + b;
          mips_pkg::fn_subu: res = a - b;
          mips_pkg::fn_and:  res = a & b;
          mips_pkg::fn_or:   res = a | b;
          mips_pkg::fn_xor:  res = a ^ b;
          mips_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mips_pkg::fn_jr: begin
            wr = 1'b0;
            m_pc = a;
            if (a == mips_pkg::halt_address) m_active = 1'b0;
          end
          default: wr = 1'b0;
        endcase
      end
      mips_pkg::op_addiu: res = a + simm;
      mips_pkg::op_andi:  res = a & {16'h0, ins[15:0]};
      mips_pkg::op_ori:   res = a | {16'h0, ins[15:0]};
      mips_pkg::op_lui:   res = {ins[15:0], 16'h0};
      mips_pkg::op_lw: begin
        exp_load = 1'b1;
        exp_addr = a + simm;
        res = m_mem[exp_addr[7:2]];
      end
      default: begin
        wr = 1'b0;
        if (ins[31:26] == mips_pkg::op_sw) begin
          exp_store = 1'b1;
          exp_addr = a + simm;
          exp_data = b;
          m_mem[exp_addr[7:2]] = b;
        end
        if (ins[31:26] == mips_pkg::op_j) m_pc = {pc4[31:28], ins[25:0], 2'b00};
        if ((ins[31:26] == mips_pkg::op_beq && a == b) ||
            (ins[31:26] == mips_pkg::op_bne && a != b)) m_pc = pc4 + (simm << 2);
      end
    endcase
    if (wr && dst != 5'd0) m_reg[dst] = res;
  endfunction

  task automatic check_word(input string name, input mips_pkg::word_t act,
                            input mips_pkg::word_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, act, exp);
      value_errors++;
    end
  endtask

  always @(negedge clk) clk_enable = (take_bits(2) != 2'b00); // low about one cycle in four

  // samples mid cycle, after the falling edge inputs have settled
  always @(negedge clk) begin
    #2;
    if (reset) begin
      check_flag("data_write", data_write, 1'b0);
      check_flag("data_read", data_read, 1'b0);
    end else begin
      check_flag("active", active, m_active);
      check_word("instr_addr", instr_addr, m_pc);
      check_word("reg_v0", reg_v0, m_reg[2]);
      if (was_frozen) begin
        check_word("instr_addr", instr_addr, frozen_addr);
        check_word("reg_v0", reg_v0, frozen_v0);
      end
      if (m_active && clk_enable) begin
        execute_model(fetch(m_pc));
        check_flag("data_write", data_write, exp_store);
        check_flag("data_read", data_read, exp_load);
        if (exp_store || exp_load) begin
          check_word("data_addr", data_addr, exp_addr);
        end
        if (exp_store) begin
          check_word("data_wdata", data_wdata, exp_data);
        end
        retired++;
      end else begin
        check_flag("data_write", data_write, 1'b0);
        check_flag("data_read", data_read, 1'b0);
      end
      was_frozen = !clk_enable;
      frozen_addr = instr_addr;
      frozen_v0 = reg_v0;
    end
  end

  initial begin
    int cycles;
    clk = 1'b0;
    reset = 1'b1;
    clk_enable = 1'b1;
    for (int i = 0; i < 64; i++) begin
      data_mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      m_mem[i] = data_mem[i];
    end
    for (int i = 0; i < 32; i++) m_reg[i] = '0;
    m_pc = mips_pkg::reset_vector;
    m_active = 1'b1;
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 1, take_bits(16)));
    prog.push_back(enc_i(mips_pkg::op_ori, 0, 2, take_bits(16)));
    prog.push_back(enc_i(mips_pkg::op_lui, 0, 3, take_bits(16)));
    prog.push_back(enc_r(mips_pkg::fn_addu, 1, 3, 4, 0));
    prog.push_back(enc_r(mips_pkg::fn_subu, 4, 2, 5, 0));
    prog.push_back(enc_r(mips_pkg::fn_and, 4, 5, 6, 0));
    prog.push_back(enc_r(mips_pkg::fn_or, 1, 2, 7, 0));
    prog.push_back(enc_r(mips_pkg::fn_xor, 7, 3, 8, 0));
    prog.push_back(enc_r(mips_pkg::fn_slt, 5, 1, 9, 0));
    prog.push_back(enc_r(mips_pkg::fn_sll, 0, 1, 10, int'(take_bits(5))));
    prog.push_back(enc_i(mips_pkg::op_andi, 8, 11, take_bits(16)));
    prog.push_back(enc_i(mips_pkg::op_addiu, 1, 0, 16'd5)); // write to r0 is dropped
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 12, 16'h0040)); // store base
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 4, 16'd0));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 5, 16'd4));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 8, 16'd8));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 10, 16'd12));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 0, 16'd16));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 9, 16'd20));
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 13, 16'd3)); // loop count
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 14, 16'd0));
    prog.push_back(enc_r(mips_pkg::fn_addu, 14, 11, 14, 0)); // loop top at index 21
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 14, 16'd24));
    prog.push_back(enc_i(mips_pkg::op_addiu, 13, 13, 16'hffff));
    prog.push_back(enc_i(mips_pkg::op_bne, 13, 0, 16'hfffc));
    prog.push_back(enc_i(mips_pkg::op_beq, 13, 0, 16'd1)); // taken
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 2, 16'h7777));
    prog.push_back(enc_i(mips_pkg::op_beq, 12, 0, 16'd1)); // not taken
    prog.push_back(enc_i(mips_pkg::op_lw, 12, 15, 16'd0));
    prog.push_back(enc_i(mips_pkg::op_bne, 0, 0, 16'd2)); // not taken
    prog.push_back(enc_i(mips_pkg::op_lw, 12, 2, 16'd4));
    prog.push_back(enc_i(mips_pkg::op_lw, 12, 16, 16'd24));
    prog.push_back({mips_pkg::op_j, 26'((mips_pkg::reset_vector + 32'd136) >> 2)});
    prog.push_back(enc_i(mips_pkg::op_addiu, 0, 2, 16'h1234));
    prog.push_back(enc_i(mips_pkg::op_lw, 12, 2, 16'd8)); // jump target at index 34
    prog.push_back(enc_r(mips_pkg::fn_addu, 2, 16, 2, 0));
    prog.push_back(enc_r(mips_pkg::fn_jr, 0, 0, 0, 0));
    prog.push_back(enc_i(mips_pkg::op_sw, 12, 1, 16'd28)); // never reached
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while (active !== 1'b0 && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    if (active !== 1'b0) begin
      $display("timeout: the core did not halt within %0d cycles", cycles);
      other_errors++;
    end
    repeat (6) @(negedge clk); // frozen state is checked by the monitor
    #5;
    $display("retired %0d, value errors %0d, other errors %0d", retired, value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/mips_pkg.sv
hdl/pc_unit.sv
hdl/control_decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/writeback_unit.sv
hdl/mips_cpu.sv
bench/mips_cpu_tb.sv

// File: Bender.yml
package:
  name: mips_cpu

sources:
  - hdl/mips_pkg.sv
  - hdl/pc_unit.sv
  - hdl/control_decoder.sv
  - hdl/regfile.sv
  - hdl/alu.sv
  - hdl/writeback_unit.sv
  - hdl/mips_cpu.sv
  - target: test
    files:
      - bench/mips_cpu_tb.sv
